// File: Makefile
TOP = readout_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: arbiter/rr_arbiter.sv
// ================================================
// round-robin arbiter, source FIFOs to output FIFO
// grant is combinational, one source per cycle
// search starts after the last granted source
// and wraps from the top source back to 0
// nothing is granted while the output FIFO is full
// ================================================
`timescale 1ns/1ps
`include "readout_defs.svh"

module rr_arbiter (
    input  logic                      CLK_40,
    input  logic                      i_rst_n,
    input  logic [`READOUT_N_SRC-1:0] i_req,
    input  readout_pkg::data_word_t   i_data [`READOUT_N_SRC],
    input  logic                      i_out_full,
    output logic [`READOUT_N_SRC-1:0] o_grant,
    output logic                      o_push,
    output readout_pkg::data_word_t   o_data
);

    localparam int N  = `READOUT_N_SRC;
    localparam int IW = $clog2(N);

    logic [N-1:0]  eligible;
    logic [IW-1:0] last_q;
    logic [IW-1:0] grant_idx;
    logic          found;

    // output back-pressure masks every request
    assign eligible = i_req & {N{~i_out_full}};

    // walk the sources once, starting one past last_q
    always_comb
    begin
        found     = 1'b0;
        grant_idx = '0;
        for (int k = 1; k <= N; k++)
        begin
            if (!found && eligible[(int'(last_q) + k) % N])
            begin
                found     = 1'b1;
                grant_idx = IW'((int'(last_q) + k) % N);
            end
        end
    end

    assign o_grant = found ? (N'(1) << grant_idx) : '0;
    assign o_push  = found;
    // mux the head of the winner, only meaningful with o_push
    assign o_data  = i_data[grant_idx];

    // rotation pointer, reset so source 0 goes first
    always_ff @(posedge CLK_40)
    begin
        if (!i_rst_n)
        begin
            last_q <= IW'(N - 1);
        end
        else if (found)
        begin
            last_q <= grant_idx;
        end
    end

endmodule

// File: build.f
+incdir+common
common/readout_pkg.sv
logic/word_fifo.sv
logic/trigger_gate.sv
logic/wb_regs.sv
arbiter/rr_arbiter.sv
logic/readout_top.sv
dv/readout_assertions.sv
dv/readout_tb.sv

// File: common/readout_defs.svh
// ================================================
// shared widths, depths and register map
// FIFO depths must stay powers of two
// source 0 is the trigger, sources 1..4 the FE channels
// ================================================
`ifndef READOUT_DEFS_SVH
`define READOUT_DEFS_SVH

// data path widths
`define READOUT_WORD_W 32
`define READOUT_PAYLOAD_W 24

// channel and arbiter source counts
`define READOUT_N_FE 4
`define READOUT_N_SRC 5

// fifo depths in words
`define READOUT_SRC_DEPTH 8
`define READOUT_OUT_DEPTH 16

// wishbone register map
`define READOUT_WB_ADR_W 4
`define READOUT_REG_SELECT 0
`define READOUT_REG_STATUS 1
`define READOUT_REG_VERSION 2
`define READOUT_REG_TRIG_COUNT 3

`define READOUT_VERSION 5

`endif

// File: common/readout_pkg.sv
// ================================================
// packed types shared by the readout core
// data_word_t must stay READOUT_WORD_W bits wide
// ================================================
`include "readout_defs.svh"

package readout_pkg;

    // one hit from a front-end channel
    typedef struct packed {
        logic                          valid;
        logic [`READOUT_PAYLOAD_W-1:0] payload;
    } fe_word_t;

    // readout word, trigger words use channel_id and payload as a 28-bit number
    typedef struct packed {
        logic                          trig_marker;
        logic [2:0]                    spare;
        logic [3:0]                    channel_id;
        logic [`READOUT_PAYLOAD_W-1:0] payload;
    } data_word_t;

    typedef struct packed {
        logic                         cyc;
        logic                         stb;
        logic                         we;
        logic [`READOUT_WB_ADR_W-1:0] adr;
        logic [`READOUT_WORD_W-1:0]   dat;
    } wb_req_t;

    typedef struct packed {
        logic                       ack;
        logic [`READOUT_WORD_W-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic       valid;
        data_word_t data;
    } out_port_t;

endpackage

// File: dv/readout_assertions.sv
// ================================================
// handshake assertions bound into readout_top
// grant and src_not_empty are top level internals
// ================================================
`timescale 1ns/1ps
`include "readout_defs.svh"

module readout_assertions (
    input logic                      CLK_40,
    input logic                      i_rst_n,
    input logic                      i_ack,
    input logic                      i_cmd_start,
    input logic                      i_out_valid,
    input logic [`READOUT_N_SRC-1:0] i_grant,
    input logic [`READOUT_N_SRC-1:0] i_src_not_empty
);

    ack_one_cycle: assert property (@(posedge CLK_40) disable iff (!i_rst_n)
        i_ack |=> !i_ack)
        else $error("wishbone ack held for more than one cycle");

    start_one_cycle: assert property (@(posedge CLK_40) disable iff (!i_rst_n)
        i_cmd_start |=> !i_cmd_start)
        else $error("cmd_start held for more than one cycle");

    // synchronous reset, so valid is low from the edge after
    no_valid_in_reset: assert property (@(posedge CLK_40)
        !i_rst_n |=> !i_out_valid)
        else $error("output valid high while reset is held");

    no_pop_empty: assert property (@(posedge CLK_40) disable iff (!i_rst_n)
        (i_grant & ~i_src_not_empty) == '0)
        else $error("arbiter popped an empty source FIFO");

endmodule

bind readout_top readout_assertions readout_assertions_i (
    .CLK_40          (CLK_40),
    .i_rst_n         (i_rst_n),
    .i_ack           (o_wb.ack),
    .i_cmd_start     (o_cmd_start),
    .i_out_valid     (o_out.valid),
    .i_grant         (grant),
    .i_src_not_empty (src_not_empty)
);

// File: dv/readout_tb.sv
// ==================================================
// readout core testbench with random stimulus from a fixed seed
// FE push rate stays below the host read rate, so no
// FIFO should overflow outside the flood test
// the flood test expects source plus output FIFO depth
// words of one channel to survive
// ==================================================
`timescale 1ns/1ps
`include "readout_defs.svh"

module readout_tb;

    localparam int N_SRC        = `READOUT_N_SRC;
    localparam int AW           = `READOUT_WB_ADR_W;
    localparam int KEEP_WORDS   = `READOUT_SRC_DEPTH + `READOUT_OUT_DEPTH;
    localparam int BURST_CYCLES = 300;
    // bursts, drains and register traffic stay well below this
    localparam int CYCLE_LIMIT  = 16 + 8 * BURST_CYCLES;

    logic                   CLK_40;
    logic                   i_rst_n;
    readout_pkg::fe_word_t  i_fe [`READOUT_N_FE];
    logic                   i_trigger;
    logic                   i_veto;
    logic                   i_cmd_ready;
    readout_pkg::wb_req_t   i_wb;
    readout_pkg::wb_rsp_t   o_wb;
    logic                   i_out_read;
    readout_pkg::out_port_t o_out;
    logic                   o_cmd_start;
    logic                   o_tlu_busy;

    // reference model with one queue of expected words per source
    logic [31:0]      exp_q [N_SRC][$];
    logic [N_SRC-1:0] sel_model;
    logic [N_SRC-1:0] masked;
    logic             busy_model;
    logic [31:0]      count_model;
    int               read_pct;
    int               errors;
    int               test_errors;
    int               tests_run;
    int               tests_failed;
    int               cycles;
    string            test_name;

    readout_top dut_i (
        .CLK_40      (CLK_40),
        .i_rst_n     (i_rst_n),
        .i_fe        (i_fe),
        .i_trigger   (i_trigger),
        .i_veto      (i_veto),
        .i_cmd_ready (i_cmd_ready),
        .i_wb        (i_wb),
        .o_wb        (o_wb),
        .i_out_read  (i_out_read),
        .o_out       (o_out),
        .o_cmd_start (o_cmd_start),
        .o_tlu_busy  (o_tlu_busy)
    );

    initial
    begin
        CLK_40 = 1'b0;
        forever #10 CLK_40 = ~CLK_40;
    end

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge CLK_40);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s: %s", test_name, msg);
        errors++;
    endtask

    // word leaving the output port is matched against its source queue
    task automatic take_word(input readout_pkg::data_word_t w);
        int src;
        src = w.trig_marker ? 0 : int'(w.channel_id);
        if (!w.trig_marker && (src < 1 || src > `READOUT_N_FE))
            note_failure($sformatf("word %h has an invalid channel id", w));
        else if (masked[src])
            note_failure($sformatf("word %h came from deselected source %0d", w, src));
        else if (exp_q[src].size() == 0)
            note_failure($sformatf("word %h from source %0d was never sent", w, src));
        else
            compare($sformatf("source %0d word", src), exp_q[src].pop_front(), w);
    endtask

    // host reader pops at random while read_pct is nonzero
    always @(negedge CLK_40)
    begin
        logic rd;
        rd = (read_pct > 0) && (($urandom % 100) < read_pct);
        i_out_read = rd;
        if (rd && o_out.valid)
            take_word(o_out.data);
    end

    task automatic wb_access(input logic we, input int adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        @(negedge CLK_40);
        i_wb = readout_pkg::wb_req_t'{cyc: 1'b1, stb: 1'b1, we: we, adr: AW'(adr), dat: wdat};
        @(negedge CLK_40);
        // ack comes one cycle after the strobe is first sampled
        compare("wishbone ack", 1, o_wb.ack);
        // master holds the strobe until ack
        while (!o_wb.ack)
            @(negedge CLK_40);
        rdat = o_wb.dat;
        i_wb = '0;
    endtask

    task automatic wb_write(input int adr, input logic [31:0] dat);
        logic [31:0] dummy;
        wb_access(1'b1, adr, dat, dummy);
    endtask

    task automatic wb_read(input int adr, output logic [31:0] dat);
        wb_access(1'b0, adr, 32'h0, dat);
    endtask

    task automatic set_select(input logic [N_SRC-1:0] sel);
        wb_write(`READOUT_REG_SELECT, 32'(sel));
        sel_model = sel;
    endtask

    task automatic fe_burst(input int n_cycles, input int pct, input logic [3:0] chans);
        logic [23:0] pl;
        logic        v;
        for (int n = 0; n < n_cycles; n++)
        begin
            @(negedge CLK_40);
            for (int c = 0; c < `READOUT_N_FE; c++)
            begin
                v  = chans[c] && (($urandom % 100) < pct);
                pl = 24'($urandom);
                i_fe[c].valid   = v;
                i_fe[c].payload = pl;
                // fe words carry channel index plus one
                if (v)
                    exp_q[c+1].push_back({1'b0, 3'b000, 4'(c + 1), pl});
            end
        end
        @(negedge CLK_40);
        for (int c = 0; c < `READOUT_N_FE; c++)
            i_fe[c].valid = 1'b0;
    endtask

    task automatic wait_drain(input logic [N_SRC-1:0] srcs);
        int left;
        do
        begin
            @(negedge CLK_40);
            left = 0;
            for (int s = 0; s < N_SRC; s++)
                if (srcs[s])
                    left += exp_q[s].size();
        end
        while (left != 0);
        // stray words still get time to show up
        repeat (8) @(negedge CLK_40);
    endtask

    task automatic trigger_pulse();
        logic accept;
        @(negedge CLK_40);
        accept    = sel_model[0] && !busy_model && !i_veto;
        i_trigger = 1'b1;
        @(negedge CLK_40);
        compare("cmd_start on trigger", accept, o_cmd_start);
        i_trigger = 1'b0;
        if (accept)
        begin
            compare("busy on trigger", 1, o_tlu_busy);
            // trigger number in the low 28 bits
            exp_q[0].push_back({1'b1, 3'b000, count_model[27:0]});
            count_model++;
            busy_model = 1'b1;
        end
        @(negedge CLK_40);
        compare("cmd_start width", 0, o_cmd_start);
        compare("busy held", busy_model, o_tlu_busy);
    endtask

    task automatic cmd_ack();
        @(negedge CLK_40);
        i_cmd_ready = 1'b1;
        @(negedge CLK_40);
        busy_model = 1'b0;
        compare("busy after cmd_ready", 0, o_tlu_busy);
        i_cmd_ready = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic close_test();
        tests_run++;
        if (errors == test_errors)
        begin
            $display("%s: ok", test_name);
        end
        else
        begin
            $display("%s: %0d error(s)", test_name, errors - test_errors);
            tests_failed++;
        end
    endtask

    initial
    begin
        logic [31:0] rd;
        void'($urandom(32'h2381));
        i_rst_n     = 1'b0;
        i_trigger   = 1'b0;
        i_veto      = 1'b0;
        i_cmd_ready = 1'b0;
        i_wb        = '0;
        i_out_read  = 1'b0;
        for (int c = 0; c < `READOUT_N_FE; c++)
            i_fe[c] = '0;
        sel_model    = '0;
        masked       = '0;
        busy_model   = 1'b0;
        count_model  = '0;
        read_pct     = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (16) @(negedge CLK_40);
        i_rst_n = 1'b1;

        begin_test("reset_state");
        wb_read(`READOUT_REG_VERSION, rd);
        compare("version", 32'd5, rd);
        wb_read(`READOUT_REG_SELECT, rd);
        compare("select", 0, rd);
        compare("out valid", 0, o_out.valid);
        compare("cmd_start", 0, o_cmd_start);
        compare("busy", 0, o_tlu_busy);
        close_test();

        begin_test("random_bursts");
        set_select(5'h1f);
        read_pct = 75;
        fe_burst(BURST_CYCLES, 12, 4'hf);
        wait_drain('1);
        wb_read(`READOUT_REG_STATUS, rd);
        compare("overflow flags", 0, rd[7:4]);
        close_test();

        // channel id 2 held back, then released
        begin_test("select_mask");
        masked = 5'b00100;
        set_select(5'h1b);
        fe_burst(30, 10, 4'b0011);
        wait_drain(5'b11011);
        repeat (20) @(negedge CLK_40);
        masked = '0;
        set_select(5'h1f);
        wait_drain('1);
        close_test();

        begin_test("trigger_handshake");
        for (int r = 0; r < 6; r++)
        begin
            i_veto = (($urandom % 3) == 0);
            trigger_pulse();
            i_veto = 1'b0;
            // lands during busy unless the first one was vetoed
            trigger_pulse();
            cmd_ack();
        end
        wait_drain(5'b00001);
        wb_read(`READOUT_REG_TRIG_COUNT, rd);
        compare("trigger count", count_model, rd);
        close_test();

        begin_test("count_clear");
        wb_write(`READOUT_REG_TRIG_COUNT, 32'h0);
        count_model = '0;
        trigger_pulse();
        cmd_ack();
        wait_drain(5'b00001);
        wb_read(`READOUT_REG_TRIG_COUNT, rd);
        compare("count after clear", count_model, rd);
        close_test();

        begin_test("flood_overflow");
        read_pct = 0;
        repeat (2) @(negedge CLK_40);
        for (int i = 0; i < 40; i++)
        begin
            @(negedge CLK_40);
            i_fe[0].valid   = 1'b1;
            i_fe[0].payload = 24'($urandom);
            // later words find both FIFOs full and are dropped
            if (i < KEEP_WORDS)
                exp_q[1].push_back({1'b0, 3'b000, 4'd1, i_fe[0].payload});
        end
        @(negedge CLK_40);
        i_fe[0].valid = 1'b0;
        wb_read(`READOUT_REG_STATUS, rd);
        compare("status after flood", 32'h13, rd[7:0]);
        wb_write(`READOUT_REG_STATUS, 32'h0);
        wb_read(`READOUT_REG_STATUS, rd);
        compare("status after clear", 32'h03, rd[7:0]);
        read_pct = 75;
        wait_drain('1);
        close_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: logic/readout_top.sv
// ================================================
// readout core top, all logic on CLK_40
// FE words are pushed whenever valid is high
// a word hitting a full source FIFO is dropped
// and sets that channel's sticky overflow flag
// host pops o_out with i_out_read pulses
// ================================================
`timescale 1ns/1ps
`include "readout_defs.svh"

module readout_top (
    input  logic                   CLK_40,
    input  logic                   i_rst_n,
    input  readout_pkg::fe_word_t  i_fe [`READOUT_N_FE],
    input  logic                   i_trigger,
    input  logic                   i_veto,
    input  logic                   i_cmd_ready,
    input  readout_pkg::wb_req_t   i_wb,
    output readout_pkg::wb_rsp_t   o_wb,
    input  logic                   i_out_read,
    output readout_pkg::out_port_t o_out,
    output logic                   o_cmd_start,
    output logic                   o_tlu_busy
);

    localparam int N_SRC = `READOUT_N_SRC;

    // per source fifo signals, index 0 is the trigger fifo
    logic [N_SRC-1:0]        src_push;
    logic [N_SRC-1:0]        src_not_empty;
    logic [N_SRC-1:0]        src_full;
    readout_pkg::data_word_t src_wdata [N_SRC];
    readout_pkg::data_word_t src_head [N_SRC];

    logic [N_SRC-1:0]        sel;
    logic [N_SRC-1:0]        grant;
    logic                    arb_push;
    readout_pkg::data_word_t arb_data;
    readout_pkg::data_word_t out_head;
    logic                    out_not_empty;
    logic                    out_full;
    logic [`READOUT_N_FE-1:0] fe_overflow;
    logic [`READOUT_WORD_W-1:0] trig_count;
    logic                    count_clear;
    logic                    trig_push;
    readout_pkg::data_word_t trig_word;

    assign src_push[0]  = trig_push;
    assign src_wdata[0] = trig_word;

    // fe words get channel index plus one as id
    for (genvar c = 0; c < `READOUT_N_FE; c++)
    begin : g_fe
        assign src_push[c+1]  = i_fe[c].valid;
        assign src_wdata[c+1] = readout_pkg::data_word_t'{
            trig_marker: 1'b0,
            spare:       3'b000,
            channel_id:  4'(c + 1),
            payload:     i_fe[c].payload
        };
        // full without a same-cycle pop means the word is lost
        assign fe_overflow[c] = i_fe[c].valid & src_full[c+1] & ~grant[c+1];
    end

    for (genvar s = 0; s < N_SRC; s++)
    begin : g_src
        word_fifo #(.DEPTH(`READOUT_SRC_DEPTH)) src_fifo_i (
            .CLK_40      (CLK_40),
            .i_rst_n     (i_rst_n),
            .i_push      (src_push[s]),
            .i_data      (src_wdata[s]),
            .i_pop       (grant[s]),
            .o_data      (src_head[s]),
            .o_not_empty (src_not_empty[s]),
            .o_full      (src_full[s])
        );
    end

    trigger_gate trigger_gate_i (
        .CLK_40        (CLK_40),
        .i_rst_n       (i_rst_n),
        .i_trigger     (i_trigger),
        .i_veto        (i_veto),
        .i_enable      (sel[0]),
        .i_cmd_ready   (i_cmd_ready),
        .i_fifo_full   (src_full[0]),
        .i_count_clear (count_clear),
        .o_cmd_start   (o_cmd_start),
        .o_tlu_busy    (o_tlu_busy),
        .o_push        (trig_push),
        .o_word        (trig_word),
        .o_count       (trig_count)
    );

    // only selected sources may request
    rr_arbiter rr_arbiter_i (
        .CLK_40     (CLK_40),
        .i_rst_n    (i_rst_n),
        .i_req      (src_not_empty & sel),
        .i_data     (src_head),
        .i_out_full (out_full),
        .o_grant    (grant),
        .o_push     (arb_push),
        .o_data     (arb_data)
    );

    word_fifo #(.DEPTH(`READOUT_OUT_DEPTH)) out_fifo_i (
        .CLK_40      (CLK_40),
        .i_rst_n     (i_rst_n),
        .i_push      (arb_push),
        .i_data      (arb_data),
        .i_pop       (i_out_read),
        .o_data      (out_head),
        .o_not_empty (out_not_empty),
        .o_full      (out_full)
    );

    assign o_out = readout_pkg::out_port_t'{valid: out_not_empty, data: out_head};

    wb_regs wb_regs_i (
        .CLK_40          (CLK_40),
        .i_rst_n         (i_rst_n),
        .i_wb            (i_wb),
        .o_wb            (o_wb),
        .i_fe_overflow   (fe_overflow),
        .i_out_not_empty (out_not_empty),
        .i_out_full      (out_full),
        .i_tlu_busy      (o_tlu_busy),
        .i_count         (trig_count),
        .o_select        (sel),
        .o_count_clear   (count_clear)
    );

endmodule

// File: logic/trigger_gate.sv
// ================================================
// external trigger gate with busy handshake
// start, busy and push are registered at the edge
// that accepts the trigger
// busy drops at the edge that sees i_cmd_ready rise
// i_count_clear wins over a same-cycle increment base
// ================================================
`timescale 1ns/1ps
`include "readout_defs.svh"

module trigger_gate (
    input  logic                       CLK_40,
    input  logic                       i_rst_n,
    input  logic                       i_trigger,
    input  logic                       i_veto,
    input  logic                       i_enable,
    input  logic                       i_cmd_ready,
    input  logic                       i_fifo_full,
    input  logic                       i_count_clear,
    output logic                       o_cmd_start,
    output logic                       o_tlu_busy,
    output logic                       o_push,
    output readout_pkg::data_word_t    o_word,
    output logic [`READOUT_WORD_W-1:0] o_count
);

    logic                       trig_q;
    logic                       rdy_q;
    logic                       accept_q;
    logic                       rise;
    logic                       ack_edge;
    logic                       accept;
    logic [`READOUT_WORD_W-1:0] count_base;

    assign rise     = i_trigger & ~trig_q;
    assign ack_edge = i_cmd_ready & ~rdy_q;
    // triggers while busy, vetoed or fifo full are simply lost
    assign accept   = rise & i_enable & ~o_tlu_busy & ~i_veto & ~i_fifo_full;
    assign count_base = i_count_clear ? '0 : o_count;

    assign o_cmd_start = accept_q;
    assign o_push      = accept_q;

    always_ff @(posedge CLK_40)
    begin
        if (!i_rst_n)
        begin
            trig_q     <= 1'b0;
            rdy_q      <= 1'b0;
            accept_q   <= 1'b0;
            o_tlu_busy <= 1'b0;
            o_count    <= '0;
        end
        else
        begin
            trig_q   <= i_trigger;
            rdy_q    <= i_cmd_ready;
            accept_q <= accept;
            o_count  <= accept ? count_base + 1'b1 : count_base;
            // accept can only happen while idle, so no conflict with ack
            if (accept)
                o_tlu_busy <= 1'b1;
            else if (ack_edge)
                o_tlu_busy <= 1'b0;
        end
    end

    // trigger word carries the count before the increment
    always_ff @(posedge CLK_40)
    begin
        if (accept)
        begin
            o_word.trig_marker <= 1'b1;
            o_word.spare       <= 3'b000;
            {o_word.channel_id, o_word.payload} <= count_base[27:0];
        end
    end

endmodule

// File: logic/wb_regs.sv
// ================================================
// Wishbone classic register slave
// ack one cycle after cyc/stb, held one cycle
// unmapped addresses ack, read 0, ignore writes
// STATUS write clears the overflow flags,
// TRIG_COUNT write pulses o_count_clear
// ================================================
`timescale 1ns/1ps
`include "readout_defs.svh"

module wb_regs (
    input  logic                       CLK_40,
    input  logic                       i_rst_n,
    input  readout_pkg::wb_req_t       i_wb,
    output readout_pkg::wb_rsp_t       o_wb,
    input  logic [`READOUT_N_FE-1:0]   i_fe_overflow,
    input  logic                       i_out_not_empty,
    input  logic                       i_out_full,
    input  logic                       i_tlu_busy,
    input  logic [`READOUT_WORD_W-1:0] i_count,
    output logic [`READOUT_N_SRC-1:0]  o_select,
    output logic                       o_count_clear
);

    localparam int W = `READOUT_WORD_W;

    logic                     ack_q;
    logic [W-1:0]             rdata_q;
    logic [W-1:0]             rdata;
    logic [W-1:0]             status;
    logic [`READOUT_N_FE-1:0] ovf_q;
    logic                     access;
    logic                     wr;

    // first cycle of a cycle/strobe, ack_q blocks a second hit
    assign access = i_wb.cyc & i_wb.stb & ~ack_q;
    assign wr     = access & i_wb.we;

    always_comb
    begin
        status    = '0;
        status[0] = i_out_not_empty;
        status[1] = i_out_full;
        status[2] = i_tlu_busy;
        status[7:4] = ovf_q;
    end

    // read mux
    always_comb
    begin
        case (i_wb.adr)
            `READOUT_REG_SELECT:     rdata = W'(o_select);
            `READOUT_REG_STATUS:     rdata = status;
            `READOUT_REG_VERSION:    rdata = W'(`READOUT_VERSION);
            `READOUT_REG_TRIG_COUNT: rdata = i_count;
            default:                 rdata = '0;
        endcase
    end

    always_ff @(posedge CLK_40)
    begin
        if (!i_rst_n)
        begin
            ack_q         <= 1'b0;
            o_select      <= '0;
            ovf_q         <= '0;
            o_count_clear <= 1'b0;
        end
        else
        begin
            ack_q         <= access;
            o_count_clear <= wr && (i_wb.adr == `READOUT_REG_TRIG_COUNT);
            if (wr && (i_wb.adr == `READOUT_REG_SELECT))
                o_select <= i_wb.dat[`READOUT_N_SRC-1:0];
            // sticky flags, a new event still lands during the clear
            if (wr && (i_wb.adr == `READOUT_REG_STATUS))
                ovf_q <= i_fe_overflow;
            else
                ovf_q <= ovf_q | i_fe_overflow;
        end
    end

    // read data lines up with ack
    always_ff @(posedge CLK_40)
    begin
        if (access)
            rdata_q <= rdata;
    end

    assign o_wb = readout_pkg::wb_rsp_t'{ack: ack_q, dat: rdata_q};

endmodule

// File: logic/word_fifo.sv
// ================================================
// synchronous FWFT FIFO of data_word_t
// DEPTH must be a power of two
// pop on empty and push on full are ignored,
// push while full is taken if a pop frees a slot
// ================================================
`timescale 1ns/1ps
`include "readout_defs.svh"

module word_fifo #(
    parameter int DEPTH = `READOUT_SRC_DEPTH
) (
    input  logic                    CLK_40,
    input  logic                    i_rst_n,
    input  logic                    i_push,
    input  readout_pkg::data_word_t i_data,
    input  logic                    i_pop,
    output readout_pkg::data_word_t o_data,
    output logic                    o_not_empty,
    output logic                    o_full
);

    localparam int AW = $clog2(DEPTH);

    readout_pkg::data_word_t mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign o_not_empty = (count != '0);
    assign o_full      = (count == (AW + 1)'(DEPTH));
    assign do_pop      = i_pop & o_not_empty;
    assign do_push     = i_push & (~o_full | do_pop);

    // head word shows straight from the array
    assign o_data = mem[rd_ptr];

    always_ff @(posedge CLK_40)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // pointers wrap by overflow
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW + 1)'(do_push) - (AW + 1)'(do_pop);
        end
    end

    always_ff @(posedge CLK_40)
    begin
        if (do_push)
            mem[wr_ptr] <= i_data;
    end

endmodule
